// File: hdl/flash_params.svh
`ifndef FLASH_PARAMS_SVH
`define FLASH_PARAMS_SVH

// ***********************************************************************
// readback buffer geometry
// ***********************************************************************
`define FLASH_BUF_DEPTH 128    // words in the readback buffer
`define FLASH_BUF_AW    7      // buffer address width

// ***********************************************************************
// request fields and spi pacing
// ***********************************************************************
`define FLASH_CNT_W     8      // word count field, 1..128 valid
`define FLASH_ADDR_W    24     // flash byte address
`define FLASH_SCK_DIV   2      // clk cycles per sck half period

`endif

// File: hdl/flash_pkg.sv
package flash_pkg;

    // flash command opcodes, as sent on mosi
    typedef enum logic [7:0]
    {
        OP_READ    = 8'h03,    // read data bytes
        OP_READ_ID = 8'h9F     // jedec id, three bytes
    } flash_op_e;

    // command sequencer
    typedef enum logic [2:0]
    {
        S_IDLE,                // wait for req
        S_CHECK,               // validate count, build header
        S_ISSUE,               // cmd_valid up
        S_WAIT,                // frame running
        S_ACK                  // hold ack until req drops
    } seq_state_e;

    // spi shifter
    typedef enum logic [1:0]
    {
        SH_IDLE,               // cs_n high
        SH_HEADER,             // opcode + address out
        SH_DATA,               // words in
        SH_END                 // guard before cs_n rises
    } shf_state_e;

endpackage

// File: hdl/shift_if.sv
`timescale 1ns/1ns
`include "flash_params.svh"

interface shift_if;

    // sequencer -> shifter
    logic                    cmd_valid;   // held until cmd_taken
    logic [31:0]             hdr_word;    // opcode in 31:24, then address
    logic [5:0]              hdr_bits;    // 8 or 32
    logic [`FLASH_CNT_W-1:0] rd_words;    // words to gather

    // shifter -> sequencer
    logic                    cmd_taken;   // same cycle as cs_n going low
    logic                    frame_done;  // single pulse at cs_n rise

    modport seq
    (
        output cmd_valid, hdr_word, hdr_bits, rd_words,
        input  cmd_taken, frame_done
    );

    modport shf
    (
        input  cmd_valid, hdr_word, hdr_bits, rd_words,
        output cmd_taken, frame_done
    );

endinterface

// File: hdl/flash_cmd_seq.sv
`timescale 1ns/1ns
`include "flash_params.svh"

module flash_cmd_seq
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req,
    input  flash_pkg::flash_op_e     op,
    input  logic [`FLASH_ADDR_W-1:0] addr,
    input  logic [`FLASH_CNT_W-1:0]  word_count,
    output logic                     ack,
    output logic                     req_error,
    shift_if.seq                     cmd
);

    import flash_pkg::*;

    localparam logic [`FLASH_CNT_W-1:0] MAX_CNT = `FLASH_CNT_W'(`FLASH_BUF_DEPTH);

    seq_state_e               state;
    flash_op_e                op_q;       // request as latched in idle
    logic [`FLASH_ADDR_W-1:0] addr_q;
    logic [`FLASH_CNT_W-1:0]  cnt_q;
    logic                     is_id;
    logic                     count_bad;

    assign is_id     = (op_q == OP_READ_ID);
    // count only matters for READ, id is always one word
    assign count_bad = !is_id && ((cnt_q == '0) || (cnt_q > MAX_CNT));

    // ********************************************************************
    // request capture and header build
    // ********************************************************************
    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && req)
        begin
            op_q   <= op;              // host holds these stable with req
            addr_q <= addr;
            cnt_q  <= word_count;
        end
        if (state == S_CHECK)
        begin
            if (is_id)
            begin
                cmd.hdr_word <= {op_q, 24'h000000};   // opcode only
                cmd.hdr_bits <= 6'd8;
                cmd.rd_words <= `FLASH_CNT_W'(1);
            end
            else
            begin
                cmd.hdr_word <= {op_q, addr_q};
                cmd.hdr_bits <= 6'd32;
                cmd.rd_words <= cnt_q;
            end
        end
    end

    // ********************************************************************
    // handshake FSM
    // ********************************************************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= S_IDLE;
            ack           <= 1'b0;
            req_error     <= 1'b0;
            cmd.cmd_valid <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (req)
                        state <= S_CHECK;
                S_CHECK:
                    if (count_bad)
                    begin
                        ack       <= 1'b1;     // reject, no frame
                        req_error <= 1'b1;
                        state     <= S_ACK;
                    end
                    else
                    begin
                        cmd.cmd_valid <= 1'b1;
                        state         <= S_ISSUE;
                    end
                S_ISSUE:
                    if (cmd.cmd_taken)
                    begin
                        cmd.cmd_valid <= 1'b0;
                        state         <= S_WAIT;
                    end
                S_WAIT:
                    if (cmd.frame_done)
                    begin
                        ack   <= 1'b1;
                        state <= S_ACK;
                    end
                S_ACK:
                    if (!req)                  // four-phase return to zero
                    begin
                        ack       <= 1'b0;
                        req_error <= 1'b0;
                        state     <= S_IDLE;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // the command offer never outlives the issue phase
    a_valid_in_issue: assert property (@(posedge clk) disable iff (reset)
        cmd.cmd_valid |-> state == S_ISSUE);

endmodule

// File: hdl/spi_shifter.sv
`timescale 1ns/1ns
`include "flash_params.svh"

module spi_shifter
(
    input  logic        clk,
    input  logic        reset,
    shift_if.shf        cmd,
    output logic        spi_cs_n,
    output logic        spi_sck,
    output logic        spi_mosi,
    input  logic        spi_miso,
    output logic        frame_start,
    output logic        rx_valid,
    output logic [31:0] rx_word
);

    import flash_pkg::*;

    localparam int DIV_W = $clog2(`FLASH_SCK_DIV) + 1;

    shf_state_e               state;
    logic [DIV_W-1:0]         div_cnt;     // clk count within an sck half
    logic [5:0]               bits_left;   // bits left in header or word
    logic [`FLASH_CNT_W-1:0]  words_left;
    logic                     is_id;       // 24 data bits instead of 32
    logic [31:0]              sreg_out;
    logic [31:0]              sreg_in;
    logic                     shifting;
    logic                     tick;
    logic                     rise;
    logic                     fall;

    assign shifting = (state == SH_HEADER) || (state == SH_DATA);
    assign tick     = (div_cnt == DIV_W'(`FLASH_SCK_DIV - 1));
    assign rise     = shifting && tick && !spi_sck;   // sample miso
    assign fall     = shifting && tick && spi_sck;    // advance mosi

    assign cmd.cmd_taken = (state == SH_IDLE) && cmd.cmd_valid;
    assign spi_mosi      = sreg_out[31];              // msb first

    // ********************************************************************
    // frame control
    // ********************************************************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state          <= SH_IDLE;
            spi_cs_n       <= 1'b1;
            spi_sck        <= 1'b0;
            div_cnt        <= '0;
            bits_left      <= '0;
            words_left     <= '0;
            is_id          <= 1'b0;
            frame_start    <= 1'b0;
            rx_valid       <= 1'b0;
            cmd.frame_done <= 1'b0;
        end
        else
        begin
            frame_start    <= 1'b0;                // pulses
            rx_valid       <= 1'b0;
            cmd.frame_done <= 1'b0;
            case (state)
                SH_IDLE:
                    if (cmd.cmd_valid)
                    begin
                        spi_cs_n    <= 1'b0;
                        div_cnt     <= '0;
                        bits_left   <= cmd.hdr_bits;
                        words_left  <= cmd.rd_words;
                        is_id       <= (cmd.hdr_bits == 6'd8);
                        frame_start <= 1'b1;       // rewinds buffer pointer
                        state       <= SH_HEADER;
                    end
                SH_HEADER, SH_DATA:
                begin
                    if (tick)
                    begin
                        div_cnt <= '0;
                        spi_sck <= !spi_sck;
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                    if (fall)
                    begin
                        if (bits_left != 6'd1)
                            bits_left <= bits_left - 1'b1;
                        else if (state == SH_HEADER)
                        begin
                            state     <= SH_DATA;
                            bits_left <= is_id ? 6'd24 : 6'd32;
                        end
                        else
                        begin
                            rx_valid <= 1'b1;      // word complete
                            if (words_left == `FLASH_CNT_W'(1))
                                state <= SH_END;
                            else
                            begin
                                words_left <= words_left - 1'b1;
                                bits_left  <= 6'd32;
                            end
                        end
                    end
                end
                SH_END:                            // two clk guard, sck low
                    if (div_cnt == DIV_W'(1))
                    begin
                        spi_cs_n       <= 1'b1;
                        cmd.frame_done <= 1'b1;
                        div_cnt        <= '0;
                        state          <= SH_IDLE;
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
            endcase
        end
    end

    // ********************************************************************
    // shift registers
    // ********************************************************************
    always_ff @(posedge clk)
    begin
        if (cmd.cmd_taken)
            sreg_out <= cmd.hdr_word;
        else if (fall)
            sreg_out <= {sreg_out[30:0], 1'b0};   // zeros follow the header
        if (rise && state == SH_DATA)
            sreg_in <= {sreg_in[30:0], spi_miso};
        if (fall && state == SH_DATA && bits_left == 6'd1)
            rx_word <= is_id ? {8'h00, sreg_in[23:0]} : sreg_in;
    end

    a_rx_in_frame: assert property (@(posedge clk) disable iff (reset)
        rx_valid |-> !spi_cs_n);
    a_sck_idle_low: assert property (@(posedge clk) disable iff (reset)
        spi_cs_n |-> !spi_sck);    // mode 0 idle level

endmodule

// File: hdl/word_buffer.sv
`timescale 1ns/1ns
`include "flash_params.svh"

module word_buffer
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     frame_start,
    input  logic                     rx_valid,
    input  logic [31:0]              rx_word,
    input  logic                     rbuf_en,
    input  logic [`FLASH_BUF_AW-1:0] rbuf_addr,
    output logic [31:0]              rbuf_data
);

    localparam int PTR_W = `FLASH_BUF_AW + 1;   // one extra bit to see full
    localparam logic [PTR_W-1:0] PTR_FULL = PTR_W'(`FLASH_BUF_DEPTH);

    logic [31:0]      mem [0:`FLASH_BUF_DEPTH-1];   // inferred sdp ram
    logic [PTR_W-1:0] wr_ptr;

    // write pointer, rewound per frame
    always_ff @(posedge clk)
    begin
        if (reset)
            wr_ptr <= '0;
        else if (frame_start)
            wr_ptr <= '0;
        else if (rx_valid)
            wr_ptr <= wr_ptr + 1'b1;
    end

    // write port
    always_ff @(posedge clk)
    begin
        if (rx_valid)
            mem[wr_ptr[`FLASH_BUF_AW-1:0]] <= rx_word;
    end

    // host read port, one cycle latency
    always_ff @(posedge clk)
    begin
        if (rbuf_en)
            rbuf_data <= mem[rbuf_addr];
    end

    // sequencer count limit must keep frames within the buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        rx_valid |-> wr_ptr != PTR_FULL);

endmodule

// File: hdl/flash_reader_top.sv
`timescale 1ns/1ns
`include "flash_params.svh"

module flash_reader_top
(
    input  logic                     clk,
    input  logic                     reset,
    // host request
    input  logic                     req,
    input  flash_pkg::flash_op_e     op,
    input  logic [`FLASH_ADDR_W-1:0] addr,
    input  logic [`FLASH_CNT_W-1:0]  word_count,
    output logic                     ack,
    output logic                     req_error,
    // spi pins
    output logic                     spi_cs_n,
    output logic                     spi_sck,
    output logic                     spi_mosi,
    input  logic                     spi_miso,
    // buffer read
    input  logic                     rbuf_en,
    input  logic [`FLASH_BUF_AW-1:0] rbuf_addr,
    output logic [31:0]              rbuf_data
);

    logic        frame_start;
    logic        rx_valid;
    logic [31:0] rx_word;

    shift_if cmd_bus ();    // sequencer to shifter

    flash_cmd_seq u_seq
    (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .word_count (word_count),
        .ack        (ack),
        .req_error  (req_error),
        .cmd        (cmd_bus.seq)
    );

    spi_shifter u_shifter
    (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd_bus.shf),
        .spi_cs_n    (spi_cs_n),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .frame_start (frame_start),
        .rx_valid    (rx_valid),
        .rx_word     (rx_word)
    );

    word_buffer u_buffer
    (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .rx_valid    (rx_valid),
        .rx_word     (rx_word),
        .rbuf_en     (rbuf_en),
        .rbuf_addr   (rbuf_addr),
        .rbuf_data   (rbuf_data)
    );

endmodule

// File: tests/spi_flash_model.sv
`timescale 1ns/1ns
`include "flash_params.svh"

module spi_flash_model
(
    input  logic spi_cs_n,
    input  logic spi_sck,
    input  logic spi_mosi,
    output logic spi_miso
);

    import flash_pkg::*;

    localparam logic [23:0] JEDEC_ID = 24'hEF4018;   // manufacturer, type, capacity

    logic [31:0]              in_sr;            // mosi history
    logic [7:0]               opcode_r;
    logic [`FLASH_ADDR_W-1:0] addr_r;
    logic [23:0]              id_sh;
    logic                     miso_r  = 1'b0;
    logic                     sck_q   = 1'b0;   // sck level at the last event
    int                       bit_cnt = 0;      // rising edges seen this frame

    assign spi_miso = miso_r;

    // byte at a is 7a + 35
    function automatic logic [7:0] mem_byte(input logic [`FLASH_ADDR_W-1:0] a);
        return 8'(7 * int'(a) + 35);
    endfunction

    // bit k of the read stream with msb first per byte
    function automatic logic data_bit(input int k);
        logic [7:0] b;
        b = mem_byte(addr_r + `FLASH_ADDR_W'(k / 8));   // wraps at top of flash
        b = b << (k % 8);
        return b[7];
    endfunction

    // sck level against its last value tells the edges apart
    always @(negedge spi_cs_n or posedge spi_sck or negedge spi_sck)
    begin
        if (spi_sck == sck_q)
        begin
            bit_cnt = 0;                          // cs_n fell, new frame
            miso_r  = 1'b0;
        end
        else if (spi_sck)
        begin
            if (!spi_cs_n)                        // mode 0 sampling edge
            begin
                in_sr   = {in_sr[30:0], spi_mosi};
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8)
                    opcode_r = in_sr[7:0];
                if (bit_cnt == 32 && opcode_r == OP_READ)
                    addr_r = in_sr[23:0];         // address follows opcode
            end
        end
        else if (!spi_cs_n)                       // drive next bit on falling sck
        begin
            if (opcode_r == OP_READ_ID && bit_cnt >= 8 && bit_cnt < 32)
            begin
                id_sh  = JEDEC_ID << (bit_cnt - 8);
                miso_r = id_sh[23];
            end
            else if (opcode_r == OP_READ && bit_cnt >= 32)
                miso_r = data_bit(bit_cnt - 32);
            else
                miso_r = 1'b0;                    // header phase
        end
        sck_q = spi_sck;
    end

endmodule

// File: tests/tb_flash_reader.sv
`timescale 1ns/1ns
`include "flash_params.svh"

module tb_flash_reader;

    import flash_pkg::*;

    localparam int CLK_NS    = 8;
    localparam int BIT_CYC   = 2 * `FLASH_SCK_DIV;   // clk cycles per sck bit
    localparam int MAX_WORDS = `FLASH_BUF_DEPTH;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     req;
    flash_op_e                op;
    logic [`FLASH_ADDR_W-1:0] addr;
    logic [`FLASH_CNT_W-1:0]  word_count;
    logic                     ack;
    logic                     req_error;
    logic                     spi_cs_n;
    logic                     spi_sck;
    logic                     spi_mosi;
    logic                     spi_miso;
    logic                     rbuf_en;
    logic [`FLASH_BUF_AW-1:0] rbuf_addr;
    logic [31:0]              rbuf_data;

    int          errors    = 0;
    int          checks    = 0;
    int          tests_run = 0;
    int          cs_falls  = 0;                     // frames started
    logic [31:0] shadow [0:`FLASH_BUF_DEPTH-1];     // expected buffer image

    flash_reader_top UUT
    (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .word_count (word_count),
        .ack        (ack),
        .req_error  (req_error),
        .spi_cs_n   (spi_cs_n),
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso),
        .rbuf_en    (rbuf_en),
        .rbuf_addr  (rbuf_addr),
        .rbuf_data  (rbuf_data)
    );

    spi_flash_model u_flash
    (
        .spi_cs_n (spi_cs_n),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    always #(CLK_NS / 2) clk = ~clk;

    always @(negedge spi_cs_n) cs_falls = cs_falls + 1;

    // ********************************************************************
    // reference values and compare tasks
    // ********************************************************************
    function automatic int frame_cycles(input int hdr_bits, input int data_bits);
        return (hdr_bits + data_bits) * BIT_CYC + 2;   // plus cs guard
    endfunction

    function automatic logic [7:0] flash_byte(input logic [`FLASH_ADDR_W-1:0] a);
        return 8'(7 * int'(a) + 35);
    endfunction

    function automatic logic [31:0] flash_word(input logic [`FLASH_ADDR_W-1:0] a);
        return {flash_byte(a), flash_byte(a + 1'b1), flash_byte(a + 2'd2), flash_byte(a + 2'd3)};
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Mismatch %s: expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("Mismatch %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic compare_cycles(input string name, input int exp, input int act);
        checks++;
        if (act != exp)
        begin
            errors++;
            $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
            $display("test %-14s ok", name);
        else
            $display("test %-14s %0d errors", name, errors - errors_before);
    endtask

    // ********************************************************************
    // host side helpers driven on the falling edge
    // ********************************************************************
    task automatic wait_for_ack(input logic level, input int limit,
                                output int waited, output bit got);
        waited = 0;
        while (ack !== level && waited < limit)
        begin
            @(negedge clk);
            waited++;
        end
        got = (ack === level);
    endtask

    task automatic run_request(input string name, input flash_op_e req_op,
                               input logic [`FLASH_ADDR_W-1:0] req_addr,
                               input logic [`FLASH_CNT_W-1:0] req_cnt,
                               output logic err, output int latency);
        int limit;
        int waited;
        bit got;
        limit = 2 * frame_cycles(req_op == OP_READ_ID ? 8 : 32,
                                 req_op == OP_READ_ID ? 24 : 32 * int'(req_cnt)) + 16;
        @(negedge clk);
        op         = req_op;
        addr       = req_addr;
        word_count = req_cnt;
        req        = 1'b1;
        wait_for_ack(1'b1, limit, latency, got);
        err = req_error;
        if (!got)
            report_error($sformatf("%s: timeout, no ack within %0d cycles", name, limit));
        @(negedge clk);
        req = 1'b0;                                  // four-phase return
        wait_for_ack(1'b0, 1, waited, got);
        if (!got)
            report_error($sformatf("%s: ack still high after req dropped", name));
        compare_flag({name, " req_error low"}, 1'b0, req_error);
    endtask

    task automatic read_buffer(input int idx, output logic [31:0] data);
        @(negedge clk);
        rbuf_en   = 1'b1;
        rbuf_addr = `FLASH_BUF_AW'(idx);
        @(negedge clk);
        rbuf_en = 1'b0;
        data    = rbuf_data;                         // one cycle latency
    endtask

    // words 0..n-1 against the formula from start
    task automatic check_read_words(input string name,
                                    input logic [`FLASH_ADDR_W-1:0] start, input int n);
        logic [31:0] data;
        logic [31:0] exp;
        for (int i = 0; i < n; i++)
        begin
            exp = flash_word(start + `FLASH_ADDR_W'(4 * i));
            read_buffer(i, data);
            compare_word($sformatf("%s word %0d", name, i), exp, data);
            shadow[`FLASH_BUF_AW'(i)] = exp;
        end
    endtask

    // ********************************************************************
    // directed tests
    // ********************************************************************
    task automatic test_reset_state();
        int e0;
        e0 = errors;
        compare_flag("reset_state ack", 1'b0, ack);
        compare_flag("reset_state req_error", 1'b0, req_error);
        compare_flag("reset_state spi_sck", 1'b0, spi_sck);
        compare_flag("reset_state spi_cs_n", 1'b1, spi_cs_n);
        finish_test("reset_state", e0);
    endtask

    task automatic test_read_single();
        int   e0;
        int   lat;
        logic err;
        e0 = errors;
        run_request("read_single", OP_READ, '0, 8'd1, err, lat);
        compare_flag("read_single req_error", 1'b0, err);
        check_read_words("read_single", '0, 1);
        finish_test("read_single", e0);
    endtask

    task automatic test_read_full();
        int                       e0;
        int                       lat;
        logic                     err;
        logic [`FLASH_ADDR_W-1:0] a;
        e0 = errors;
        a  = `FLASH_ADDR_W'($urandom);
        run_request("read_full", OP_READ, a, `FLASH_CNT_W'(MAX_WORDS), err, lat);
        compare_flag("read_full req_error", 1'b0, err);
        check_read_words("read_full", a, MAX_WORDS);
        finish_test("read_full", e0);
    endtask

    task automatic test_read_id();
        int          e0;
        int          lat;
        logic        err;
        logic [31:0] data;
        e0 = errors;
        run_request("read_id", OP_READ_ID, '0, 8'd0, err, lat);   // count ignored
        compare_flag("read_id req_error", 1'b0, err);
        read_buffer(0, data);
        compare_word("read_id word 0", 32'h00EF4018, data);
        shadow[0] = 32'h00EF4018;
        finish_test("read_id", e0);
    endtask

    task automatic test_bad_count();
        int          e0;
        int          lat;
        int          falls0;
        logic        err;
        logic [31:0] data;
        e0     = errors;
        falls0 = cs_falls;
        foreach (shadow[i])
        begin
            if (i == 0)
            begin
                run_request("bad_count_0", OP_READ, '0, 8'd0, err, lat);
                compare_flag("bad_count_0 req_error", 1'b1, err);
                compare_cycles("bad_count_0 ack latency", 2, lat);
                run_request("bad_count_200", OP_READ, '0, 8'd200, err, lat);
                compare_flag("bad_count_200 req_error", 1'b1, err);
                compare_cycles("bad_count_200 ack latency", 2, lat);
                if (cs_falls != falls0)
                    report_error("bad_count: chip select went low for a rejected request");
            end
            read_buffer(i, data);                    // buffer left untouched
            compare_word($sformatf("bad_count word %0d", i), shadow[i], data);
        end
        finish_test("bad_count", e0);
    endtask

    task automatic test_back_to_back();
        int                       e0;
        int                       lat;
        int                       n;
        logic                     err;
        logic [`FLASH_ADDR_W-1:0] a;
        e0 = errors;
        for (int t = 0; t < 10; t++)
        begin
            a = `FLASH_ADDR_W'($urandom);
            n = 1 + int'($urandom % MAX_WORDS);
            run_request($sformatf("burst_%0d", t), OP_READ, a, `FLASH_CNT_W'(n), err, lat);
            compare_flag($sformatf("burst_%0d req_error", t), 1'b0, err);
            check_read_words($sformatf("burst_%0d", t), a, n);
        end
        finish_test("back_to_back", e0);
    endtask

    // ********************************************************************
    // watchdog and main sequence
    // ********************************************************************
    initial
    begin
        int limit_ns;
        // twice the worst case frames of all tests
        limit_ns = 2 * CLK_NS * (frame_cycles(32, 32) + frame_cycles(32, 32 * MAX_WORDS)
                   + frame_cycles(8, 24) + 10 * frame_cycles(32, 32 * MAX_WORDS));
        #(limit_ns);
        $display("watchdog: run did not finish within %0d ns", limit_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(35849));
        reset      = 1'b1;
        req        = 1'b0;
        op         = OP_READ;
        addr       = '0;
        word_count = '0;
        rbuf_en    = 1'b0;
        rbuf_addr  = '0;
        repeat (4) @(negedge clk);                   // 4 cycles of reset
        reset = 1'b0;

        test_reset_state();
        test_read_single();
        test_read_full();
        test_read_id();
        test_bad_count();
        test_back_to_back();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: build.f
+incdir+hdl
hdl/flash_pkg.sv
hdl/shift_if.sv
hdl/flash_cmd_seq.sv
hdl/spi_shifter.sv
hdl/word_buffer.sv
hdl/flash_reader_top.sv
tests/spi_flash_model.sv
tests/tb_flash_reader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the flash reader testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_flash_reader

verilator --binary --timing --assert -f build.f --top-module tb_flash_reader \
    -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0
